/* include/vec_unit_cfg.svh */
`ifndef VEC_UNIT_CFG_SVH
`define VEC_UNIT_CFG_SVH

////////////////////////////////////////
// Datapath geometry
////////////////////////////////////////

// Number of lanes, must stay a power of two
`define VEC_NR_LANES 4

// Elements per vector register
`define VEC_VLMAX 32

// Element and scalar width in bits
`define VEC_ELEM_W 32

// Architectural vector registers
`define VEC_NR_VREGS 8

////////////////////////////////////////
// Queue depths
////////////////////////////////////////

`define VEC_INSN_DEPTH 4
`define VEC_RES_DEPTH 2

`endif

/* source/vec_pkg.sv */
`include "vec_unit_cfg.svh"

package vec_pkg;

  ////////////////////////////////////////
  // Scalar and index types
  ////////////////////////////////////////

  // One element, also used for scalar operands and results
  typedef logic [`VEC_ELEM_W-1:0] elem_t;

  // Vector length, needs to hold VLMAX itself
  typedef logic [$clog2(`VEC_VLMAX+1)-1:0] vlen_t;

  // Vector register number
  typedef logic [$clog2(`VEC_NR_VREGS)-1:0] vreg_idx_t;

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    VSETVL  = 4'd0,
    VID     = 4'd1,
    VMV_VX  = 4'd2,
    VADD_VV = 4'd3,
    VSUB_VV = 4'd4,
    VAND_VV = 4'd5,
    VXOR_VV = 4'd6,
    VADD_VX = 4'd7,
    VEXT_XV = 4'd8
  } vec_op_e;

  ////////////////////////////////////////
  // Instruction and lane request
  ////////////////////////////////////////

  // As received on the instruction port
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
  } vec_instr_t;

  // Same fields, plus the vl in force for this operation
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
    vlen_t     vl;
  } vec_pe_req_t;

endpackage

/* source/vec_fifo.sv */
`timescale 1ns/100ps

module vec_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned depth     = 2
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o
);

  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  payload_t mem_q [depth];

  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == cnt_w'(depth));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  // Pointers wrap at depth, which need not be a power of two
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

/* source/vec_lane.sv */
`timescale 1ns/100ps

`include "vec_unit_cfg.svh"

module vec_lane #(
  parameter int unsigned lane_id = 0
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  vec_pkg::vec_pe_req_t pe_req_i,
  input  logic                 pe_req_valid_i,
  output logic                 done_o,
  output vec_pkg::elem_t       ext_o,
  output logic                 ext_valid_o
);

  localparam int unsigned elems  = `VEC_VLMAX / `VEC_NR_LANES;
  localparam int unsigned slot_w = $clog2(elems);
  localparam int unsigned lane_w = $clog2(`VEC_NR_LANES);
  localparam logic [lane_w-1:0] lane_bits = lane_w'(lane_id);

  // Register slice, slot s holds element s * NR_LANES + lane_id
  vec_pkg::elem_t vrf_q [`VEC_NR_VREGS][elems];

  vec_pkg::vec_pe_req_t req_q;
  logic                 busy_q;
  logic [slot_w-1:0]    slot_q;
  logic [slot_w-1:0]    last_q;
  logic [slot_w-1:0]    last_slot;
  logic [slot_w-1:0]    ext_slot;
  vec_pkg::vlen_t       vl_m1;
  vec_pkg::vlen_t       elem_idx;
  vec_pkg::elem_t       op_a;
  vec_pkg::elem_t       op_b;
  vec_pkg::elem_t       wr_data;
  logic                 wr_en;
  logic                 ext_own;

  ////////////////////////////////////////
  // Element sequencing
  ////////////////////////////////////////

  // ceil(vl / NR_LANES) slots, a single cycle for vl of zero or an extract
  assign vl_m1     = pe_req_i.vl - 1'b1;
  assign last_slot = (pe_req_i.op == vec_pkg::VEXT_XV || pe_req_i.vl == '0) ? '0
                   : slot_w'(vl_m1 >> lane_w);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      slot_q <= '0;
      last_q <= '0;
    end else if (pe_req_valid_i) begin
      busy_q <= 1'b1;
      slot_q <= '0;
      last_q <= last_slot;
    end else if (busy_q) begin
      if (slot_q == last_q) begin
        busy_q <= 1'b0;
      end else begin
        slot_q <= slot_q + 1'b1;
      end
    end
  end

  assign done_o   = busy_q && (slot_q == last_q);
  assign elem_idx = vec_pkg::vlen_t'({slot_q, lane_bits});

  ////////////////////////////////////////
  // Element ALU
  ////////////////////////////////////////

  assign op_a = vrf_q[req_q.vs1][slot_q];
  assign op_b = vrf_q[req_q.vs2][slot_q];

  // Binary ops compute vs2 op vs1, tail elements stay untouched
  always_comb begin
    wr_en   = busy_q && (elem_idx < req_q.vl);
    wr_data = '0;
    case (req_q.op)
      vec_pkg::VID:     wr_data = vec_pkg::elem_t'(elem_idx);
      vec_pkg::VMV_VX:  wr_data = req_q.scalar;
      vec_pkg::VADD_VV: wr_data = op_b + op_a;
      vec_pkg::VSUB_VV: wr_data = op_b - op_a;
      vec_pkg::VAND_VV: wr_data = op_b & op_a;
      vec_pkg::VXOR_VV: wr_data = op_b ^ op_a;
      vec_pkg::VADD_VX: wr_data = op_b + req_q.scalar;
      default:          wr_en   = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (pe_req_valid_i) begin
      req_q <= pe_req_i;
    end
    if (wr_en) begin
      vrf_q[req_q.vd][slot_q] <= wr_data;
    end
  end

  ////////////////////////////////////////
  // Scalar extract
  ////////////////////////////////////////

  assign ext_slot    = req_q.scalar[lane_w +: slot_w];
  assign ext_own     = (req_q.scalar < `VEC_VLMAX) && (req_q.scalar[lane_w-1:0] == lane_bits);
  assign ext_o       = vrf_q[req_q.vs2][ext_slot];
  assign ext_valid_o = done_o && (req_q.op == vec_pkg::VEXT_XV) && ext_own;

endmodule

/* source/vec_dispatcher.sv */
`timescale 1ns/100ps

`include "vec_unit_cfg.svh"

module vec_dispatcher (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // Instruction port
  input  vec_pkg::vec_instr_t instr_i,
  input  logic                instr_valid_i,
  output logic                instr_ready_o,
  // Towards the sequencer
  output vec_pkg::vec_pe_req_t req_o,
  output logic                 req_valid_o,
  input  logic                 req_ready_i,
  output logic                 empty_o
);

  vec_pkg::vec_instr_t head;
  vec_pkg::vlen_t      vl_q;
  vec_pkg::vlen_t      vsetvl_vl;
  logic                insn_full;
  logic                insn_empty;
  logic                is_vsetvl;
  logic                handover;

  ////////////////////////////////////////
  // Instruction queue
  ////////////////////////////////////////

  vec_fifo #(
    .payload_t (vec_pkg::vec_instr_t),
    .depth     (`VEC_INSN_DEPTH)
  ) i_insn_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (instr_valid_i),
    .data_i   (instr_i),
    .full_o   (insn_full),
    .pop_i    (handover),
    .data_o   (head),
    .empty_o  (insn_empty)
  );

  assign instr_ready_o = !insn_full;
  assign req_valid_o   = !insn_empty;
  assign handover      = req_valid_o && req_ready_i;
  assign empty_o       = insn_empty;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  assign is_vsetvl = (head.op == vec_pkg::VSETVL);

  // New vl is min(scalar, VLMAX)
  assign vsetvl_vl = (head.scalar >= `VEC_VLMAX) ? vec_pkg::vlen_t'(`VEC_VLMAX)
                                                 : vec_pkg::vlen_t'(head.scalar);

  always_comb begin
    req_o.op     = head.op;
    req_o.vd     = head.vd;
    req_o.vs1    = head.vs1;
    req_o.vs2    = head.vs2;
    req_o.scalar = head.scalar;
    // A VSETVL carries its own clamped length so the sequencer can answer it
    req_o.vl     = is_vsetvl ? vsetvl_vl : vl_q;
  end

  ////////////////////////////////////////
  // Vector-length CSR
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vl_q <= '0;
    end else if (handover && is_vsetvl) begin
      vl_q <= vsetvl_vl;
    end
  end

endmodule

/* source/vec_sequencer.sv */
`timescale 1ns/100ps

`include "vec_unit_cfg.svh"

module vec_sequencer (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,
  // From the dispatcher
  input  vec_pkg::vec_pe_req_t                       req_i,
  input  logic                                       req_valid_i,
  output logic                                       req_ready_o,
  // Lane broadcast and completion
  output vec_pkg::vec_pe_req_t                       pe_req_o,
  output logic                                       pe_req_valid_o,
  input  logic                   [`VEC_NR_LANES-1:0] done_i,
  input  vec_pkg::elem_t         [`VEC_NR_LANES-1:0] ext_i,
  input  logic                   [`VEC_NR_LANES-1:0] ext_valid_i,
  // Result queue
  output logic                                       push_o,
  output vec_pkg::elem_t                             res_data_o,
  input  logic                                       full_i,
  output logic                                       idle_o
);

  typedef enum logic {st_idle, st_busy} state_e;

  state_e                   state_q;
  vec_pkg::vec_pe_req_t     pe_req_q;
  logic                     pe_req_valid_q;
  logic [`VEC_NR_LANES-1:0] done_q;
  vec_pkg::elem_t           ext_q;
  vec_pkg::elem_t           ext_sel;
  vec_pkg::elem_t           res_q;
  logic                     push_q;
  logic                     res_op;
  logic                     take;
  logic                     all_done;
  logic                     ext_hit;

  // Result producers wait for room, counting the push still in flight
  assign res_op      = (req_i.op == vec_pkg::VSETVL) || (req_i.op == vec_pkg::VEXT_XV);
  assign req_ready_o = (state_q == st_idle) && (!res_op || (!full_i && !push_q));
  assign take        = req_valid_i && req_ready_o;
  assign all_done    = &(done_q | done_i);

  // At most one lane owns the index
  always_comb begin
    ext_sel = '0;
    for (int l = 0; l < `VEC_NR_LANES; l++) begin
      ext_sel = ext_sel | (ext_valid_i[l] ? ext_i[l] : '0);
    end
  end
  assign ext_hit = |ext_valid_i;

  ////////////////////////////////////////
  // Issue FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q        <= st_idle;
      pe_req_valid_q <= 1'b0;
      push_q         <= 1'b0;
      done_q         <= '0;
    end else begin
      pe_req_valid_q <= 1'b0;
      push_q         <= 1'b0;
      case (state_q)
        st_idle: begin
          if (take && req_i.op == vec_pkg::VSETVL) begin
            push_q <= 1'b1;
          end else if (take) begin
            state_q        <= st_busy;
            pe_req_valid_q <= 1'b1;
            done_q         <= '0;
          end
        end
        default: begin
          done_q <= done_q | done_i;
          if (all_done) begin
            state_q <= st_idle;
            push_q  <= (pe_req_q.op == vec_pkg::VEXT_XV);
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      pe_req_q <= req_i;
    end
    // Index beyond VLMAX has no owner and reads back as zero
    if (take) begin
      ext_q <= '0;
    end else if (ext_hit) begin
      ext_q <= ext_sel;
    end
    if (take && req_i.op == vec_pkg::VSETVL) begin
      res_q <= vec_pkg::elem_t'(req_i.vl);
    end else if (state_q == st_busy && all_done) begin
      res_q <= ext_hit ? ext_sel : ext_q;
    end
  end

  assign pe_req_o       = pe_req_q;
  assign pe_req_valid_o = pe_req_valid_q;
  assign push_o         = push_q;
  assign res_data_o     = res_q;
  assign idle_o         = (state_q == st_idle) && !push_q;

endmodule

/* source/vec_unit_top.sv */
`timescale 1ns/100ps

`include "vec_unit_cfg.svh"

module vec_unit_top (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // Instruction port
  input  vec_pkg::vec_instr_t instr_i,
  input  logic                instr_valid_i,
  output logic                instr_ready_o,
  // Result port
  output vec_pkg::elem_t      res_o,
  output logic                res_valid_o,
  input  logic                res_ready_i,
  output logic                idle_o
);

  vec_pkg::vec_pe_req_t                     req;
  logic                                     req_valid;
  logic                                     req_ready;
  logic                                     insn_empty;
  vec_pkg::vec_pe_req_t                     pe_req;
  logic                                     pe_req_valid;
  logic           [`VEC_NR_LANES-1:0]       lane_done;
  vec_pkg::elem_t [`VEC_NR_LANES-1:0]       lane_ext;
  logic           [`VEC_NR_LANES-1:0]       lane_ext_valid;
  logic                                     res_push;
  vec_pkg::elem_t                           res_data;
  logic                                     res_full;
  logic                                     res_empty;
  logic                                     seq_idle;

  ////////////////////////////////////////
  // Dispatcher and sequencer
  ////////////////////////////////////////

  vec_dispatcher i_dispatcher (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .instr_ready_o (instr_ready_o),
    .req_o         (req),
    .req_valid_o   (req_valid),
    .req_ready_i   (req_ready),
    .empty_o       (insn_empty)
  );

  vec_sequencer i_sequencer (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .req_i          (req),
    .req_valid_i    (req_valid),
    .req_ready_o    (req_ready),
    .pe_req_o       (pe_req),
    .pe_req_valid_o (pe_req_valid),
    .done_i         (lane_done),
    .ext_i          (lane_ext),
    .ext_valid_i    (lane_ext_valid),
    .push_o         (res_push),
    .res_data_o     (res_data),
    .full_i         (res_full),
    .idle_o         (seq_idle)
  );

  ////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////

  for (genvar l = 0; l < `VEC_NR_LANES; l++) begin : gen_lanes
    vec_lane #(
      .lane_id (l)
    ) i_lane (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .pe_req_i       (pe_req),
      .pe_req_valid_i (pe_req_valid),
      .done_o         (lane_done[l]),
      .ext_o          (lane_ext[l]),
      .ext_valid_o    (lane_ext_valid[l])
    );
  end

  // Result queue towards the outside
  vec_fifo #(
    .payload_t (vec_pkg::elem_t),
    .depth     (`VEC_RES_DEPTH)
  ) i_res_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (res_push),
    .data_i   (res_data),
    .full_o   (res_full),
    .pop_i    (res_ready_i),
    .data_o   (res_o),
    .empty_o  (res_empty)
  );

  assign res_valid_o = !res_empty;

  // Sequencer idle already covers the lanes
  assign idle_o = insn_empty && res_empty && seq_idle;

endmodule

/* testbench/vec_unit_props.sv */
`timescale 1ns/100ps

`include "vec_unit_cfg.svh"

module vec_unit_props (
  input logic                clk_i,
  input logic                arst_n_i,
  input vec_pkg::vec_instr_t instr_i,
  input logic                instr_valid_i,
  input logic                instr_ready_o,
  input vec_pkg::elem_t      res_o,
  input logic                res_valid_o,
  input logic                res_ready_i,
  input logic                idle_o
);

  ////////////////////////////////////////
  // Configuration
  ////////////////////////////////////////

  initial begin
    assert ((`VEC_NR_LANES & (`VEC_NR_LANES - 1)) == 0)
      else $error("Lane count is not a power of two");
    assert ((`VEC_VLMAX % `VEC_NR_LANES) == 0)
      else $error("VLMAX is not a multiple of the lane count");
  end

  ////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////

  instr_stable_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (instr_valid_i && !instr_ready_o) |=> (instr_valid_i && $stable(instr_i))
  ) else $error("Instruction changed before it was accepted");

  res_stable_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_o))
  ) else $error("Result changed before it was taken");

  // Idle unit stays idle until an instruction arrives
  idle_hold_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (idle_o && !instr_valid_i) |=> idle_o
  ) else $error("Unit left idle without a new instruction");

endmodule

bind vec_unit_top vec_unit_props i_props (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .instr_i       (instr_i),
  .instr_valid_i (instr_valid_i),
  .instr_ready_o (instr_ready_o),
  .res_o         (res_o),
  .res_valid_o   (res_valid_o),
  .res_ready_i   (res_ready_i),
  .idle_o        (idle_o)
);

/* testbench/vec_unit_tb.sv */
`timescale 1ns/100ps

`include "vec_unit_cfg.svh"

module vec_unit_tb;

  localparam int unsigned seed        = 65603;
  localparam int unsigned wait_limit  = 200;
  localparam int unsigned nr_random   = 300;
  localparam int unsigned burst_limit = 16;

  logic                clk;
  logic                arst_n;
  vec_pkg::vec_instr_t instr;
  logic                instr_valid;
  logic                instr_ready;
  vec_pkg::elem_t      res;
  logic                res_valid;
  logic                res_ready;
  logic                idle;

  // Reference state of the vector unit
  vec_pkg::elem_t model_vrf [`VEC_NR_VREGS][`VEC_VLMAX];
  int unsigned    model_vl;
  vec_pkg::elem_t exp_q [$];

  vec_pkg::vec_op_e arith_ops [7] = '{vec_pkg::VID, vec_pkg::VMV_VX, vec_pkg::VADD_VV,
                                      vec_pkg::VSUB_VV, vec_pkg::VAND_VV, vec_pkg::VXOR_VV,
                                      vec_pkg::VADD_VX};

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  vec_unit_top dut_i (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .instr_i       (instr),
    .instr_valid_i (instr_valid),
    .instr_ready_o (instr_ready),
    .res_o         (res),
    .res_valid_o   (res_valid),
    .res_ready_i   (res_ready),
    .idle_o        (idle)
  );

  ////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped after an error");
  endtask

  task automatic check_eq(input string test, input vec_pkg::elem_t exp,
                          input vec_pkg::elem_t act);
    if (exp !== act) begin
      report_failure($sformatf("ERR %s expected %0h actual %0h", test, exp, act));
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Returns 1 when the instruction produces a result
  function automatic logic model_exec(input vec_pkg::vec_instr_t ins,
                                      output vec_pkg::elem_t result);
    vec_pkg::elem_t a;
    vec_pkg::elem_t b;
    logic           has_res;
    has_res = 1'b0;
    result  = '0;
    case (ins.op)
      vec_pkg::VSETVL: begin
        model_vl = (ins.scalar > `VEC_VLMAX) ? `VEC_VLMAX : ins.scalar;
        result   = model_vl;
        has_res  = 1'b1;
      end
      vec_pkg::VEXT_XV: begin
        if (ins.scalar < `VEC_VLMAX) begin
          result = model_vrf[ins.vs2][int'(ins.scalar)];
        end
        has_res = 1'b1;
      end
      default: begin
        // Only elements below vl change
        for (int i = 0; i < int'(model_vl); i++) begin
          a = model_vrf[ins.vs1][i];
          b = model_vrf[ins.vs2][i];
          case (ins.op)
            vec_pkg::VID:     model_vrf[ins.vd][i] = i;
            vec_pkg::VMV_VX:  model_vrf[ins.vd][i] = ins.scalar;
            vec_pkg::VADD_VV: model_vrf[ins.vd][i] = b + a;
            vec_pkg::VSUB_VV: model_vrf[ins.vd][i] = b - a;
            vec_pkg::VAND_VV: model_vrf[ins.vd][i] = b & a;
            vec_pkg::VXOR_VV: model_vrf[ins.vd][i] = b ^ a;
            vec_pkg::VADD_VX: model_vrf[ins.vd][i] = b + ins.scalar;
            default:          model_vrf[ins.vd][i] = model_vrf[ins.vd][i];
          endcase
        end
      end
    endcase
    return has_res;
  endfunction

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  function automatic vec_pkg::vec_instr_t make_instr(input vec_pkg::vec_op_e op,
                                                     input vec_pkg::elem_t scalar);
    vec_pkg::vec_instr_t ins;
    ins.op     = op;
    ins.vd     = vec_pkg::vreg_idx_t'($urandom);
    ins.vs1    = vec_pkg::vreg_idx_t'($urandom);
    ins.vs2    = vec_pkg::vreg_idx_t'($urandom);
    ins.scalar = scalar;
    return ins;
  endfunction

  // Mostly in range, sometimes past VLMAX
  function automatic vec_pkg::elem_t rand_index();
    int unsigned pick;
    pick = $urandom_range(7);
    if (pick == 0) begin
      return $urandom | 32'h8000_0000;
    end else if (pick == 1) begin
      return `VEC_VLMAX + $urandom_range(31);
    end
    return $urandom_range(`VEC_VLMAX - 1);
  endfunction

  // Inputs change on the falling edge only
  task automatic send_instr(input vec_pkg::vec_instr_t ins);
    int unsigned cycles;
    cycles = 0;
    while (!instr_ready) begin
      if (cycles == wait_limit) begin
        report_failure("Timeout: the instruction port never became ready");
      end
      cycles++;
      @(negedge clk);
    end
    instr       = ins;
    instr_valid = 1'b1;
    @(negedge clk);
    instr_valid = 1'b0;
  endtask

  task automatic get_result(output vec_pkg::elem_t val);
    int unsigned cycles;
    cycles = 0;
    while (!res_valid) begin
      if (cycles == wait_limit) begin
        report_failure("Timeout: no result arrived on the result port");
      end
      cycles++;
      @(negedge clk);
    end
    val       = res;
    res_ready = 1'b1;
    @(negedge clk);
    res_ready = 1'b0;
  endtask

  task automatic run_instr(input string test, input vec_pkg::vec_instr_t ins);
    vec_pkg::elem_t exp;
    vec_pkg::elem_t act;
    logic           has_res;
    has_res = model_exec(ins, exp);
    send_instr(ins);
    if (has_res) begin
      get_result(act);
      check_eq(test, exp, act);
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    vec_pkg::vec_instr_t ins;
    vec_pkg::elem_t      exp;
    vec_pkg::elem_t      act;
    logic                dropped;
    int unsigned         pick;
    int unsigned         cycles;

    void'($urandom(seed));
    arst_n      = 1'b0;
    instr       = '0;
    instr_valid = 1'b0;
    res_ready   = 1'b0;
    model_vl    = 0;
    repeat (2) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    // Reset state
    check_eq("reset_instr_ready", 1, vec_pkg::elem_t'(instr_ready));
    check_eq("reset_idle", 1, vec_pkg::elem_t'(idle));
    check_eq("reset_res_valid", 0, vec_pkg::elem_t'(res_valid));

    // VSETVL clamping around VLMAX
    for (int n = 0; n < 24; n++) begin
      exp = (n % 3 == 0) ? $urandom : $urandom_range(2 * `VEC_VLMAX);
      run_instr("vsetvl_clamp", make_instr(vec_pkg::VSETVL, exp));
    end

    // Known contents in every register before any read
    run_instr("init", make_instr(vec_pkg::VSETVL, `VEC_VLMAX));
    for (int r = 0; r < `VEC_NR_VREGS; r++) begin
      ins    = make_instr(vec_pkg::VMV_VX, $urandom);
      ins.vd = vec_pkg::vreg_idx_t'(r);
      run_instr("init", ins);
    end

    // Random arithmetic with extract read-back
    for (int n = 0; n < nr_random; n++) begin
      pick = $urandom_range(7);
      if (pick == 0) begin
        ins = make_instr(vec_pkg::VSETVL, $urandom_range(`VEC_VLMAX + 8));
      end else if (pick < 4) begin
        ins = make_instr(vec_pkg::VEXT_XV, rand_index());
      end else begin
        ins = make_instr(arith_ops[$urandom_range(6)], $urandom);
      end
      run_instr($sformatf("arith_%s", ins.op.name()), ins);
    end

    // Tail undisturbed
    run_instr("tail", make_instr(vec_pkg::VSETVL, `VEC_VLMAX));
    ins    = make_instr(vec_pkg::VMV_VX, $urandom);
    ins.vd = 3'd5;
    run_instr("tail", ins);
    run_instr("tail", make_instr(vec_pkg::VSETVL, $urandom_range(9, 1)));
    ins     = make_instr(vec_pkg::VADD_VX, $urandom);
    ins.vd  = 3'd5;
    ins.vs2 = 3'd5;
    run_instr("tail", ins);
    for (int i = 0; i < `VEC_VLMAX; i++) begin
      ins     = make_instr(vec_pkg::VEXT_XV, i);
      ins.vs2 = 3'd5;
      run_instr($sformatf("tail_elem_%0d", i), ins);
    end

    // Back-pressure with the result port blocked
    dropped = 1'b0;
    for (int k = 0; k < burst_limit && !dropped; k++) begin
      if (!instr_ready) begin
        dropped = 1'b1;
      end else begin
        if ($urandom_range(1) == 0) begin
          ins = make_instr(vec_pkg::VSETVL, $urandom_range(48));
        end else begin
          ins = make_instr(vec_pkg::VEXT_XV, rand_index());
        end
        void'(model_exec(ins, exp));
        exp_q.push_back(exp);
        send_instr(ins);
      end
    end
    if (!dropped) begin
      report_failure("instr_ready_o never dropped while the result port was blocked");
    end
    while (exp_q.size() > 0) begin
      get_result(act);
      check_eq("backpressure", exp_q.pop_front(), act);
    end

    // Return to idle
    cycles = 0;
    while (!idle) begin
      if (cycles == wait_limit) begin
        report_failure("Timeout: idle_o did not return high after the last result");
      end
      cycles++;
      @(negedge clk);
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* vec_unit.f */
+incdir+include
source/vec_pkg.sv
source/vec_fifo.sv
source/vec_lane.sv
source/vec_dispatcher.sv
source/vec_sequencer.sv
source/vec_unit_top.sv
testbench/vec_unit_props.sv
testbench/vec_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the vector unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module vec_unit_tb -f vec_unit.f -o vec_unit_sim \
  || { echo "Verilator build failed"; exit 1; }

out=$(./obj_dir/vec_unit_sim 2>&1)
echo "$out"

echo "$out" | grep -q "TESTBENCH PASSED" \
  && echo "Simulation run succeeded" \
  || { echo "Simulation run did not pass"; exit 1; }
